// ==== dcache_pkg.sv ====
package dcache_pkg;

	// default geometry, the top level may override these per instance
	localparam int ADDR_W     = 32;
	localparam int WAYS       = 2;
	localparam int SETS       = 16;
	localparam int LINE_BYTES = 16;
	localparam int BEATS      = LINE_BYTES / 4;  // 32-bit beats per line
	localparam int WB_DEPTH   = 2;               // also the starting credit count

	// address split: tag | index | offset
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int INDEX_W  = $clog2(SETS);
	localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

	typedef logic [LINE_BYTES*8-1:0] line_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [31:0]       wdata;
		logic [3:0]        strb;
		logic              write;
	} cpu_req_t;

	// what a way shows for the indexed set
	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
		line_t            line;
	} way_entry_t;

	// full entry write into one way
	typedef struct packed {
		logic               en;
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0]   tag;
		line_t              line;
		logic               valid;
		logic               dirty;
	} way_wr_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;  // line aligned
		line_t             line;
	} wb_entry_t;

	typedef enum logic [2:0] {
		IDLE,
		CHECK,
		EVICT,
		WAIT_WB,
		REFILL,
		DONE
	} ctrl_state_e;

endpackage

// ==== cache_way.sv ====
`timescale 1ns/1ps

module cache_way #(
	parameter int SETS = dcache_pkg::SETS,
	localparam int INDEX_W = $clog2(SETS)
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [INDEX_W-1:0]     index,
	input  dcache_pkg::way_wr_t    wr,
	input  logic                   wr_sel,
	output dcache_pkg::way_entry_t entry
);

	// state bits per set
	logic [SETS-1:0] valid_q;
	logic [SETS-1:0] dirty_q;

	// tag and data arrays
	logic [dcache_pkg::TAG_W-1:0] tag_mem [SETS];
	dcache_pkg::line_t            line_mem [SETS];

	logic write;

	assign write = wr.en && wr_sel;  // only the selected way takes the write

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (write) begin
			valid_q[wr.index] <= wr.valid;
			dirty_q[wr.index] <= wr.dirty;
		end
	end

	always_ff @(posedge clock) begin
		if (write) begin
			tag_mem[wr.index]  <= wr.tag;
			line_mem[wr.index] <= wr.line;
		end
	end

	// combinational lookup of the indexed set
	always_comb begin
		entry.valid = valid_q[index];
		entry.dirty = dirty_q[index];
		entry.tag   = tag_mem[index];
		entry.line  = line_mem[index];  // tag/line are don't care while invalid
	end

endmodule

// ==== way_select.sv ====
`timescale 1ns/1ps

module way_select #(
	parameter int WAYS       = dcache_pkg::WAYS,
	parameter int SETS       = dcache_pkg::SETS,
	parameter int LINE_BYTES = dcache_pkg::LINE_BYTES,
	localparam int WAY_W     = (WAYS > 1) ? $clog2(WAYS) : 1,
	localparam int OFFSET_W  = $clog2(LINE_BYTES),
	localparam int INDEX_W   = $clog2(SETS),
	localparam int TAG_W     = dcache_pkg::ADDR_W - INDEX_W - OFFSET_W
) (
	input  logic                   clock,
	input  logic                   reset,
	input  dcache_pkg::way_entry_t entries [WAYS],
	input  dcache_pkg::cpu_req_t   req,
	input  logic                   check,
	output logic                   hit,
	output logic [WAY_W-1:0]       hit_way,
	output logic [31:0]            rdata,
	output logic [WAY_W-1:0]       victim_way,
	output logic                   victim_dirty,
	output logic [TAG_W-1:0]       victim_tag,
	output dcache_pkg::line_t      victim_line
);

	logic [WAY_W-1:0]    rr_q [SETS];  // replacement pointer per set
	logic [TAG_W-1:0]    req_tag;
	logic [INDEX_W-1:0]  index;
	logic [OFFSET_W-3:0] word;
	dcache_pkg::line_t   hit_line;

	assign req_tag = req.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
	assign index   = req.addr[OFFSET_W +: INDEX_W];
	assign word    = req.addr[OFFSET_W-1:2];

	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int i = 0; i < WAYS; i++) begin
			if (entries[i].valid && entries[i].tag == req_tag) begin
				hit     = 1'b1;
				hit_way = WAY_W'(i);
			end
		end
	end

	assign hit_line = entries[hit_way].line;
	assign rdata    = hit_line[word*32 +: 32];  // whole aligned word

	// lowest invalid way wins, else round robin
	always_comb begin
		victim_way = rr_q[index];
		for (int i = WAYS - 1; i >= 0; i--) begin
			if (!entries[i].valid) begin
				victim_way = WAY_W'(i);
			end
		end
	end

	assign victim_dirty = entries[victim_way].valid && entries[victim_way].dirty;
	assign victim_tag   = entries[victim_way].tag;
	assign victim_line  = entries[victim_way].line;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < SETS; s++) begin
				rr_q[s] <= '0;
			end
		end else if (check && !hit) begin
			// step once per missing request
			rr_q[index] <= (rr_q[index] == WAY_W'(WAYS - 1)) ? '0 : rr_q[index] + 1'b1;
		end
	end

endmodule

// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl #(
	parameter int WAYS       = dcache_pkg::WAYS,
	parameter int SETS       = dcache_pkg::SETS,
	parameter int LINE_BYTES = dcache_pkg::LINE_BYTES,
	parameter int WB_DEPTH   = dcache_pkg::WB_DEPTH,
	localparam int WAY_W     = (WAYS > 1) ? $clog2(WAYS) : 1,
	localparam int OFFSET_W  = $clog2(LINE_BYTES),
	localparam int INDEX_W   = $clog2(SETS),
	localparam int TAG_W     = dcache_pkg::ADDR_W - INDEX_W - OFFSET_W
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          cpu_sel,
	input  dcache_pkg::cpu_req_t          cpu_req,
	output logic                          cpu_ready,
	output logic [31:0]                   cpu_rdata,
	input  logic                          hit,
	input  logic [WAY_W-1:0]              hit_way,
	input  dcache_pkg::line_t             hit_entry_line,
	input  logic [31:0]                   rdata,
	input  logic [WAY_W-1:0]              victim_way,
	input  logic                          victim_dirty,
	input  logic [TAG_W-1:0]              victim_tag,
	input  dcache_pkg::line_t             victim_line,
	output logic [INDEX_W-1:0]            lookup_index,
	output logic                          check,
	output dcache_pkg::way_wr_t           way_wr,
	output logic [WAYS-1:0]               way_wr_sel,
	output logic                          wb_push,
	output dcache_pkg::wb_entry_t         wb_entry,
	input  logic                          wb_credit,
	output logic                          mem_rd_req,
	output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr,
	input  logic                          mem_rd_valid,
	input  logic                          mem_rd_last,
	input  logic [31:0]                   mem_rd_data
);

	localparam int LINE_W = LINE_BYTES * 8;
	localparam int CNT_W  = $clog2(WB_DEPTH + 1);

	dcache_pkg::ctrl_state_e state_q;
	dcache_pkg::ctrl_state_e state_d;

	logic [CNT_W-1:0]    credit_q;
	logic                credits_full;
	logic [TAG_W-1:0]    req_tag;
	logic [OFFSET_W-3:0] word;
	logic                last_beat;

	// victim captured at the miss, the selector moves on afterwards
	logic [WAY_W-1:0]  victim_way_q;
	logic [TAG_W-1:0]  victim_tag_q;
	dcache_pkg::line_t victim_line_q;

	dcache_pkg::line_t refill_q;
	dcache_pkg::line_t fill_line;

	// byte merge of the store word into a line
	function automatic dcache_pkg::line_t merge_store(
		input dcache_pkg::line_t   line,
		input logic [OFFSET_W-3:0] wsel,
		input logic [31:0]         wdata,
		input logic [3:0]          strb
	);
		dcache_pkg::line_t merged;
		merged = line;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				merged[wsel*32 + b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	assign req_tag      = cpu_req.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
	assign lookup_index = cpu_req.addr[OFFSET_W +: INDEX_W];
	assign word         = cpu_req.addr[OFFSET_W-1:2];
	assign check        = (state_q == dcache_pkg::CHECK);
	assign last_beat    = mem_rd_valid && mem_rd_last;
	assign credits_full = (credit_q == CNT_W'(WB_DEPTH));  // write buffer drained

	// beats arrive lowest address first
	assign fill_line = {mem_rd_data, refill_q[LINE_W-1:32]};

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= dcache_pkg::IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			dcache_pkg::IDLE: begin
				if (cpu_sel) begin
					state_d = dcache_pkg::CHECK;
				end
			end
			dcache_pkg::CHECK: begin
				if (hit) begin
					state_d = dcache_pkg::IDLE;
				end else if (victim_dirty) begin
					state_d = dcache_pkg::EVICT;
				end else begin
					state_d = dcache_pkg::WAIT_WB;
				end
			end
			dcache_pkg::EVICT: begin
				if (wb_push) begin
					state_d = dcache_pkg::WAIT_WB;
				end
			end
			dcache_pkg::WAIT_WB: begin
				if (credits_full) begin
					state_d = dcache_pkg::REFILL;
				end
			end
			dcache_pkg::REFILL: begin
				if (last_beat) begin
					state_d = dcache_pkg::DONE;
				end
			end
			default: begin
				state_d = dcache_pkg::IDLE;  // DONE
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (check && !hit) begin
			victim_way_q  <= victim_way;
			victim_tag_q  <= victim_tag;
			victim_line_q <= victim_line;
		end
		if (state_q == dcache_pkg::REFILL && mem_rd_valid) begin
			refill_q <= fill_line;
		end
	end

	// one credit per buffer slot
	always_ff @(posedge clock) begin
		if (reset) begin
			credit_q <= CNT_W'(WB_DEPTH);
		end else begin
			credit_q <= credit_q - CNT_W'(wb_push) + CNT_W'(wb_credit);
		end
	end

	assign wb_push       = (state_q == dcache_pkg::EVICT) && (credit_q != '0);
	assign wb_entry.addr = {victim_tag_q, lookup_index, {OFFSET_W{1'b0}}};
	assign wb_entry.line = victim_line_q;

	assign mem_rd_req  = (state_q == dcache_pkg::WAIT_WB) && credits_full;
	assign mem_rd_addr = {cpu_req.addr[dcache_pkg::ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	// store hit in CHECK, line install on the last refill beat
	always_comb begin
		way_wr       = '0;
		way_wr_sel   = '0;
		way_wr.index = lookup_index;
		way_wr.tag   = req_tag;
		way_wr.valid = 1'b1;
		if (check && hit && cpu_req.write) begin
			way_wr.en           = 1'b1;
			way_wr.line         = merge_store(hit_entry_line, word, cpu_req.wdata, cpu_req.strb);
			way_wr.dirty        = 1'b1;
			way_wr_sel[hit_way] = 1'b1;
		end else if (state_q == dcache_pkg::REFILL && last_beat) begin
			way_wr.en   = 1'b1;
			way_wr.line = cpu_req.write ?
				merge_store(fill_line, word, cpu_req.wdata, cpu_req.strb) : fill_line;
			way_wr.dirty             = cpu_req.write;
			way_wr_sel[victim_way_q] = 1'b1;
		end
	end

	// in DONE the installed line hits, so the selector word is the answer
	assign cpu_ready = (check && hit) || (state_q == dcache_pkg::DONE);
	assign cpu_rdata = rdata;

endmodule

// ==== write_buffer.sv ====
`timescale 1ns/1ps

module write_buffer #(
	parameter int WB_DEPTH = dcache_pkg::WB_DEPTH,
	localparam int PTR_W   = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1,
	localparam int CNT_W   = $clog2(WB_DEPTH + 1)
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  push,
	input  dcache_pkg::wb_entry_t push_entry,
	output logic                  credit,
	output logic                  mem_wr_valid,
	input  logic                  mem_wr_ready,
	output dcache_pkg::wb_entry_t mem_wr_entry
);

	dcache_pkg::wb_entry_t fifo_mem [WB_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             pop;
	logic             credit_q;

	// wrap for any depth, not just powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(WB_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign mem_wr_valid = (count_q != '0);
	assign pop          = mem_wr_valid && mem_wr_ready;  // memory took the head
	assign mem_wr_entry = fifo_mem[rd_ptr_q];

	always_ff @(posedge clock) begin
		if (push) begin
			fifo_mem[wr_ptr_q] <= push_entry;  // credits guarantee a free slot
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			count_q  <= count_q + CNT_W'(push) - CNT_W'(pop);
			credit_q <= pop;  // credit goes back a cycle after the handshake
		end
	end

	assign credit = credit_q;

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top #(
	parameter int WAYS       = dcache_pkg::WAYS,
	parameter int SETS       = dcache_pkg::SETS,
	parameter int LINE_BYTES = dcache_pkg::LINE_BYTES,
	parameter int WB_DEPTH   = dcache_pkg::WB_DEPTH
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          cpu_sel,
	input  dcache_pkg::cpu_req_t          cpu_req,
	output logic                          cpu_ready,
	output logic [31:0]                   cpu_rdata,
	output logic                          mem_wr_valid,
	input  logic                          mem_wr_ready,
	output dcache_pkg::wb_entry_t         mem_wr_entry,
	output logic                          mem_rd_req,
	output logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr,
	input  logic                          mem_rd_valid,
	input  logic                          mem_rd_last,
	input  logic [31:0]                   mem_rd_data
);

	localparam int WAY_W    = (WAYS > 1) ? $clog2(WAYS) : 1;
	localparam int OFFSET_W = $clog2(LINE_BYTES);
	localparam int INDEX_W  = $clog2(SETS);
	localparam int TAG_W    = dcache_pkg::ADDR_W - INDEX_W - OFFSET_W;

	dcache_pkg::way_entry_t entries [WAYS];

	logic                  hit;
	logic [WAY_W-1:0]      hit_way;
	logic [31:0]           rdata;
	logic [WAY_W-1:0]      victim_way;
	logic                  victim_dirty;
	logic [TAG_W-1:0]      victim_tag;
	dcache_pkg::line_t     victim_line;
	logic [INDEX_W-1:0]    lookup_index;
	logic                  check;
	dcache_pkg::way_wr_t   way_wr;
	logic [WAYS-1:0]       way_wr_sel;
	logic                  wb_push;
	dcache_pkg::wb_entry_t wb_entry;
	logic                  wb_credit;

	cache_ctrl #(
		.WAYS      (WAYS),
		.SETS      (SETS),
		.LINE_BYTES(LINE_BYTES),
		.WB_DEPTH  (WB_DEPTH)
	) i_ctrl (
		.clock         (clock),
		.reset         (reset),
		.cpu_sel       (cpu_sel),
		.cpu_req       (cpu_req),
		.cpu_ready     (cpu_ready),
		.cpu_rdata     (cpu_rdata),
		.hit           (hit),
		.hit_way       (hit_way),
		.hit_entry_line(entries[hit_way].line),
		.rdata         (rdata),
		.victim_way    (victim_way),
		.victim_dirty  (victim_dirty),
		.victim_tag    (victim_tag),
		.victim_line   (victim_line),
		.lookup_index  (lookup_index),
		.check         (check),
		.way_wr        (way_wr),
		.way_wr_sel    (way_wr_sel),
		.wb_push       (wb_push),
		.wb_entry      (wb_entry),
		.wb_credit     (wb_credit),
		.mem_rd_req    (mem_rd_req),
		.mem_rd_addr   (mem_rd_addr),
		.mem_rd_valid  (mem_rd_valid),
		.mem_rd_last   (mem_rd_last),
		.mem_rd_data   (mem_rd_data)
	);

	// one storage block per way, all see the same index and write bus
	for (genvar i = 0; i < WAYS; i++) begin : g_way
		cache_way #(
			.SETS(SETS)
		) i_way (
			.clock (clock),
			.reset (reset),
			.index (lookup_index),
			.wr    (way_wr),
			.wr_sel(way_wr_sel[i]),
			.entry (entries[i])
		);
	end

	way_select #(
		.WAYS      (WAYS),
		.SETS      (SETS),
		.LINE_BYTES(LINE_BYTES)
	) i_select (
		.clock       (clock),
		.reset       (reset),
		.entries     (entries),
		.req         (cpu_req),
		.check       (check),
		.hit         (hit),
		.hit_way     (hit_way),
		.rdata       (rdata),
		.victim_way  (victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag  (victim_tag),
		.victim_line (victim_line)
	);

	write_buffer #(
		.WB_DEPTH(WB_DEPTH)
	) i_wbuf (
		.clock       (clock),
		.reset       (reset),
		.push        (wb_push),
		.push_entry  (wb_entry),
		.credit      (wb_credit),
		.mem_wr_valid(mem_wr_valid),
		.mem_wr_ready(mem_wr_ready),
		.mem_wr_entry(mem_wr_entry)
	);

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache;

	localparam int WAYS        = dcache_pkg::WAYS;
	localparam int SETS        = dcache_pkg::SETS;
	localparam int LINE_BYTES  = dcache_pkg::LINE_BYTES;
	localparam int WB_DEPTH    = dcache_pkg::WB_DEPTH;
	localparam int BEATS       = LINE_BYTES / 4;
	localparam int WINDOW      = 3 * WAYS * SETS * LINE_BYTES;  // three cache spans in bytes
	localparam int NUM_REQS    = 400;
	localparam int MISS_BOUND  = 60;  // worst case cycles per request
	localparam int CYCLE_LIMIT = NUM_REQS * MISS_BOUND;

	logic                          clock;
	logic                          reset;
	logic                          cpu_sel;
	dcache_pkg::cpu_req_t          cpu_req;
	logic                          cpu_ready;
	logic [31:0]                   cpu_rdata;
	logic                          mem_wr_valid;
	logic                          mem_wr_ready;
	dcache_pkg::wb_entry_t         mem_wr_entry;
	logic                          mem_rd_req;
	logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr;
	logic                          mem_rd_valid;
	logic                          mem_rd_last;
	logic [31:0]                   mem_rd_data;

	logic [7:0] mem_bytes [WINDOW];  // backing memory
	logic [7:0] ref_bytes [WINDOW];  // what every load should see

	// lines the cache must hold, per set and way
	logic        res_valid [SETS][WAYS];
	int unsigned res_tag   [SETS][WAYS];
	int unsigned res_rr    [SETS];

	int unsigned cycle_count = 0;

	dcache_top #(
		.WAYS      (WAYS),
		.SETS      (SETS),
		.LINE_BYTES(LINE_BYTES),
		.WB_DEPTH  (WB_DEPTH)
	) i_dut (
		.clock       (clock),
		.reset       (reset),
		.cpu_sel     (cpu_sel),
		.cpu_req     (cpu_req),
		.cpu_ready   (cpu_ready),
		.cpu_rdata   (cpu_rdata),
		.mem_wr_valid(mem_wr_valid),
		.mem_wr_ready(mem_wr_ready),
		.mem_wr_entry(mem_wr_entry),
		.mem_rd_req  (mem_rd_req),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_valid(mem_rd_valid),
		.mem_rd_last (mem_rd_last),
		.mem_rd_data (mem_rd_data)
	);

	always #50 clock = ~clock;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic logic [7:0] fill_byte(input int unsigned a);
		return 8'((a * 29) ^ (a >> 5));
	endfunction

	// lowest address in the low byte
	function automatic logic [31:0] ref_word(input int unsigned a);
		return {ref_bytes[a+3], ref_bytes[a+2], ref_bytes[a+1], ref_bytes[a]};
	endfunction

	function automatic logic [31:0] mem_word(input int unsigned a);
		return {mem_bytes[a+3], mem_bytes[a+2], mem_bytes[a+1], mem_bytes[a]};
	endfunction

	// returns the predicted hit and installs the line on a miss
	function automatic logic track_residency(input int unsigned addr);
		int unsigned set_idx;
		int unsigned tag;
		int unsigned victim;
		set_idx = (addr / LINE_BYTES) % SETS;
		tag     = addr / (LINE_BYTES * SETS);
		for (int w = 0; w < WAYS; w++) begin
			if (res_valid[set_idx][w] && res_tag[set_idx][w] == tag) begin
				return 1'b1;
			end
		end
		// empty way first, else the round robin pick
		victim = res_rr[set_idx];
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!res_valid[set_idx][w]) begin
				victim = w;
			end
		end
		res_rr[set_idx]            = (res_rr[set_idx] + 1) % WAYS;  // steps on every miss
		res_valid[set_idx][victim] = 1'b1;
		res_tag[set_idx][victim]   = tag;
		return 1'b0;
	endfunction

	task automatic run_requests();
		dcache_pkg::cpu_req_t req;
		logic [31:0]          expected;
		logic                 will_hit;
		int unsigned          idle;
		int unsigned          latency;
		int unsigned          a;
		for (int n = 0; n < NUM_REQS; n++) begin
			idle = $urandom_range(0, 2);
			if (idle != 0) begin
				cpu_sel = 1'b0;
				repeat (idle) begin
					@(posedge clock);
					#1;
				end
			end
			a         = $urandom_range(0, WINDOW / 4 - 1) * 4;
			req.addr  = a;
			req.write = $urandom_range(0, 1);
			req.wdata = $urandom;
			req.strb  = req.write ? 4'($urandom_range(1, 15)) : 4'hf;  // mostly partial
			expected  = ref_word(a);
			will_hit  = track_residency(a);
			cpu_sel   = 1'b1;
			cpu_req   = req;
			latency   = 0;
			@(posedge clock);
			while (!cpu_ready) begin
				@(posedge clock);
				latency++;
			end
			if (!req.write) begin
				assert (cpu_rdata === expected) else
					abort_run($sformatf("Mismatch at %0t: load addr %h expected %h got %h",
						$time, a, expected, cpu_rdata));
			end else begin
				for (int b = 0; b < 4; b++) begin
					if (req.strb[b]) begin
						ref_bytes[a+b] = req.wdata[b*8 +: 8];
					end
				end
			end
			if (will_hit) begin
				assert (latency == 1) else
					abort_run($sformatf("Mismatch at %0t: addr %h hit latency 1 expected, got %0d",
						$time, a, latency));
			end else begin
				assert (latency > 1) else
					abort_run($sformatf("Mismatch at %0t: addr %h should miss, ready after %0d",
						$time, a, latency));
			end
			#1;
		end
		cpu_sel = 1'b0;
	endtask

	// memory read side with a random first delay and gaps between beats
	task automatic serve_reads();
		int unsigned base;
		int unsigned wait_cycles;
		int unsigned gap;
		forever begin
			@(posedge clock);
			if (mem_rd_req) begin
				base = mem_rd_addr;
				assert (mem_rd_addr % LINE_BYTES == 0) else
					abort_run($sformatf("Mismatch at %0t: read addr %h not line aligned",
						$time, mem_rd_addr));
				assert (base < WINDOW) else
					abort_run($sformatf("read request outside the test window at %0t", $time));
				assert (!mem_wr_valid) else
					abort_run($sformatf("read requested at %0t with a write still buffered",
						$time));
				wait_cycles = $urandom_range(1, 4);
				#1;
				repeat (wait_cycles) begin
					@(posedge clock);
					#1;
				end
				for (int b = 0; b < BEATS; b++) begin
					mem_rd_valid = 1'b1;
					mem_rd_data  = mem_word(base + 4 * b);
					mem_rd_last  = (b == BEATS - 1);
					@(posedge clock);
					#1;
					mem_rd_valid = 1'b0;
					mem_rd_last  = 1'b0;
					gap = (b < BEATS - 1) ? $urandom_range(0, 2) : 0;
					repeat (gap) begin
						@(posedge clock);
						#1;
					end
				end
			end
		end
	endtask

	task automatic toggle_write_ready();
		forever begin
			@(posedge clock);
			#1;
			mem_wr_ready = ($urandom_range(0, 3) != 0);  // ready three times in four
		end
	endtask

	// memory write side checked against the reference as the line leaves
	always @(posedge clock) begin : accept_writes
		int unsigned       base;
		dcache_pkg::line_t expected_line;
		if (!reset && mem_wr_valid && mem_wr_ready) begin
			base = mem_wr_entry.addr;
			assert (mem_wr_entry.addr % LINE_BYTES == 0) else
				abort_run($sformatf("Mismatch at %0t: write addr %h not line aligned",
					$time, mem_wr_entry.addr));
			assert (base < WINDOW) else
				abort_run($sformatf("write outside the test window at %0t", $time));
			for (int k = 0; k < LINE_BYTES; k++) begin
				expected_line[k*8 +: 8] = ref_bytes[base+k];
			end
			assert (mem_wr_entry.line === expected_line) else
				abort_run($sformatf("Mismatch at %0t: write addr %h expected %h got %h",
					$time, base, expected_line, mem_wr_entry.line));
			for (int k = 0; k < LINE_BYTES; k++) begin
				mem_bytes[base+k] = mem_wr_entry.line[k*8 +: 8];
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		assert (cycle_count < CYCLE_LIMIT) else
			abort_run($sformatf("timeout, run not finished within %0d cycles", CYCLE_LIMIT));
	end

	initial begin
		void'($urandom(35872));  // forked threads draw from this stream
		clock        = 1'b0;
		reset        = 1'b1;
		cpu_sel      = 1'b0;
		cpu_req      = '0;
		mem_wr_ready = 1'b0;
		mem_rd_valid = 1'b0;
		mem_rd_last  = 1'b0;
		mem_rd_data  = '0;
		for (int a = 0; a < WINDOW; a++) begin
			mem_bytes[a] = fill_byte(a);
			ref_bytes[a] = mem_bytes[a];
		end
		for (int s = 0; s < SETS; s++) begin
			res_rr[s] = 0;
			for (int w = 0; w < WAYS; w++) begin
				res_valid[s][w] = 1'b0;
				res_tag[s][w]   = 0;
			end
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		assert (!cpu_ready && !mem_rd_req && !mem_wr_valid) else
			abort_run("outputs not low after reset");
		fork
			run_requests();
			serve_reads();
			toggle_write_ready();
		join_any
		$display("test passed");
		$finish;
	end

endmodule

// ==== compile.f ====
dcache_pkg.sv
cache_way.sv
way_select.sv
cache_ctrl.sv
write_buffer.sv
dcache_top.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - cache_way.sv
  - way_select.sv
  - cache_ctrl.sv
  - write_buffer.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv
